// File: rtl/core_pkg.sv
/*
 * Core package
 * Widths, counts and the tag and data word types shared by the
 * reservation station, register file, ALU lanes and CDB arbiter
 */
package core_pkg;

	localparam int DATA_W    = 64;
	localparam int TAG_W     = 6;
	localparam int NUM_TAGS  = 64;  // Tag 0 reads as constant zero
	localparam int NUM_LANES = 3;
	localparam int RS_DEPTH  = 8;
	localparam int RS_IDX_W  = $clog2(RS_DEPTH);

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [TAG_W-1:0]     ptag_t;
	typedef logic [NUM_LANES-1:0] lane_mask_t;  // One bit per ALU lane

endpackage

// File: rtl/isa_pkg.sv
/*
 * ISA package
 * ALU function codes, the operand-B field and the layout of one
 * dispatched instruction
 */
package isa_pkg;

	import core_pkg::*;

	localparam int IMM_W = 16;

	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_SLL   = 3'd5,
		ALU_SRL   = 3'd6,
		ALU_CMPEQ = 3'd7
	} alu_func_t;

	// Same bits seen as a source tag or as an immediate
	typedef union packed {
		struct packed {
			logic [IMM_W-TAG_W-1:0] rsvd;
			ptag_t                  tag;
		} src;
		logic [IMM_W-1:0] imm;  // Zero-extended on use
	} opb_field_t;

	typedef struct packed {
		alu_func_t  func;
		ptag_t      dest;
		ptag_t      src_a;
		logic       opb_is_imm;
		opb_field_t opb;
	} dispatch_t;  // 32 bits

endpackage

// File: rtl/lane_ifs.sv
/*
 * Lane interfaces
 * issue_if carries an operand-ready instruction from the reservation
 * station to an ALU lane, result_if carries a finished result from a
 * lane to the CDB arbiter. Both use a valid/ready handshake
 */
interface issue_if import core_pkg::*, isa_pkg::*; ();

	logic      valid;
	logic      ready;
	alu_func_t func;
	data_t     opa;
	data_t     opb;
	ptag_t     dest;

	modport rs_side (output valid, func, opa, opb, dest, input ready);
	modport lane_side (input valid, func, opa, opb, dest, output ready);

endinterface

interface result_if import core_pkg::*; ();

	logic  valid;
	logic  ready;
	ptag_t tag;
	data_t value;

	modport lane_side (output valid, tag, value, input ready);
	modport arb_side (input valid, tag, value, output ready);

endinterface

// File: rtl/phys_reg_file.sv
/*
 * Physical register file
 * 64 values with one valid bit per tag. Two combinational read
 * ports for dispatch, one write port fed by the CDB. Tag 0 is
 * always valid and reads as zero
 */
module phys_reg_file import core_pkg::*; (
	input  logic  clock,
	input  logic  rst_n,
	input  ptag_t rd_tag_a,
	input  ptag_t rd_tag_b,
	input  logic  alloc_valid,
	input  ptag_t alloc_tag,
	input  logic  cdb_valid,
	input  ptag_t cdb_tag,
	input  data_t cdb_value,
	output data_t rd_value_a,
	output logic  rd_ready_a,
	output data_t rd_value_b,
	output logic  rd_ready_b
);

	data_t               regs [NUM_TAGS];
	logic [NUM_TAGS-1:0] tag_valid;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tag_valid <= {{(NUM_TAGS-1){1'b0}}, 1'b1};
		end else begin
			if (cdb_valid)
				tag_valid[cdb_tag] <= 1'b1;
			if (alloc_valid && alloc_tag != '0)  // New producer pending
				tag_valid[alloc_tag] <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (cdb_valid)
			regs[cdb_tag] <= cdb_value;
	end

	assign rd_value_a = (rd_tag_a == '0) ? '0 : regs[rd_tag_a];
	assign rd_value_b = (rd_tag_b == '0) ? '0 : regs[rd_tag_b];
	assign rd_ready_a = tag_valid[rd_tag_a];
	assign rd_ready_b = tag_valid[rd_tag_b];

endmodule

// File: rtl/res_station.sv
/*
 * Reservation station
 * Accepts one instruction per cycle, captures operands from the PRF,
 * the CDB or an immediate, wakes waiting entries on broadcasts and
 * offers ready entries to the ALU lanes, lowest index first
 */
module res_station import core_pkg::*, isa_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      dispatch_valid,
	input  dispatch_t dispatch_instr,
	output logic      dispatch_ready,
	output ptag_t     rd_tag_a,
	output ptag_t     rd_tag_b,
	input  data_t     rd_value_a,
	input  logic      rd_ready_a,
	input  data_t     rd_value_b,
	input  logic      rd_ready_b,
	output logic      alloc_valid,
	output ptag_t     alloc_tag,
	input  logic      cdb_valid,
	input  ptag_t     cdb_tag,
	input  data_t     cdb_value,
	issue_if.rs_side  issue [NUM_LANES]
);

	logic [RS_DEPTH-1:0] ent_valid;
	logic [RS_DEPTH-1:0] ent_a_rdy;
	logic [RS_DEPTH-1:0] ent_b_rdy;
	alu_func_t           ent_func [RS_DEPTH];
	ptag_t               ent_dest [RS_DEPTH];
	ptag_t               ent_a_tag [RS_DEPTH];
	ptag_t               ent_b_tag [RS_DEPTH];
	data_t               ent_a_val [RS_DEPTH];
	data_t               ent_b_val [RS_DEPTH];

	logic [RS_DEPTH-1:0] ent_issued;
	logic [RS_IDX_W-1:0] free_idx;
	logic [NUM_LANES-1:0] lane_ready;
	logic [NUM_LANES-1:0] sel_valid;
	logic [RS_IDX_W-1:0] sel_idx [NUM_LANES];
	logic                new_a_rdy, new_b_rdy;
	data_t               new_a_val, new_b_val;

	assign dispatch_ready = ~&ent_valid;
	assign alloc_valid    = dispatch_valid && dispatch_ready;
	assign alloc_tag      = dispatch_instr.dest;
	assign rd_tag_a       = dispatch_instr.src_a;
	assign rd_tag_b       = dispatch_instr.opb.src.tag;

	always_comb begin
		free_idx = '0;
		for (int e = RS_DEPTH - 1; e >= 0; e--) begin
			if (!ent_valid[e])
				free_idx = RS_IDX_W'(e);
		end
	end

	// Operand capture, PRF first then a same-cycle broadcast
	always_comb begin
		new_a_rdy = rd_ready_a;
		new_a_val = rd_value_a;
		if (!rd_ready_a && cdb_valid && cdb_tag == rd_tag_a) begin
			new_a_rdy = 1'b1;
			new_a_val = cdb_value;
		end
		if (dispatch_instr.opb_is_imm) begin
			new_b_rdy = 1'b1;
			new_b_val = {{(DATA_W-IMM_W){1'b0}}, dispatch_instr.opb.imm};
		end else begin
			new_b_rdy = rd_ready_b;
			new_b_val = rd_value_b;
			if (!rd_ready_b && cdb_valid && cdb_tag == rd_tag_b) begin
				new_b_rdy = 1'b1;
				new_b_val = cdb_value;
			end
		end
	end

	// Each ready lane takes the lowest ready entry left by lower lanes
	always_comb begin
		logic [RS_DEPTH-1:0] avail;
		avail      = ent_valid & ent_a_rdy & ent_b_rdy;
		ent_issued = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			sel_valid[l] = 1'b0;
			sel_idx[l]   = '0;
			if (lane_ready[l]) begin
				for (int e = RS_DEPTH - 1; e >= 0; e--) begin
					if (avail[e]) begin
						sel_valid[l] = 1'b1;
						sel_idx[l]   = RS_IDX_W'(e);
					end
				end
			end
			if (sel_valid[l]) begin
				avail[sel_idx[l]]      = 1'b0;
				ent_issued[sel_idx[l]] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ent_valid <= '0;
		end else begin
			ent_valid <= ent_valid & ~ent_issued;
			if (alloc_valid)
				ent_valid[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		for (int e = 0; e < RS_DEPTH; e++) begin
			if (cdb_valid && !ent_a_rdy[e] && ent_a_tag[e] == cdb_tag) begin
				ent_a_rdy[e] <= 1'b1;
				ent_a_val[e] <= cdb_value;
			end
			if (cdb_valid && !ent_b_rdy[e] && ent_b_tag[e] == cdb_tag) begin
				ent_b_rdy[e] <= 1'b1;
				ent_b_val[e] <= cdb_value;
			end
		end
		if (alloc_valid) begin  // Overrides any wakeup on the free slot
			ent_func[free_idx]  <= dispatch_instr.func;
			ent_dest[free_idx]  <= dispatch_instr.dest;
			ent_a_tag[free_idx] <= rd_tag_a;
			ent_b_tag[free_idx] <= rd_tag_b;
			ent_a_rdy[free_idx] <= new_a_rdy;
			ent_b_rdy[free_idx] <= new_b_rdy;
			ent_a_val[free_idx] <= new_a_val;
			ent_b_val[free_idx] <= new_b_val;
		end
	end

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_issue
		assign lane_ready[l]  = issue[l].ready;
		assign issue[l].valid = sel_valid[l];
		assign issue[l].func  = ent_func[sel_idx[l]];
		assign issue[l].opa   = ent_a_val[sel_idx[l]];
		assign issue[l].opb   = ent_b_val[sel_idx[l]];
		assign issue[l].dest  = ent_dest[sel_idx[l]];
	end

endmodule

// File: rtl/alu_lane.sv
/*
 * ALU lane
 * Two-stage pipe. Stage one registers the issued operands, stage two
 * holds the computed result until the CDB arbiter takes it
 */
module alu_lane import core_pkg::*, isa_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	issue_if.lane_side issue,
	result_if.lane_side result
);

	logic      s1_valid, s2_valid;
	alu_func_t s1_func;
	data_t     s1_a, s1_b;
	ptag_t     s1_dest, s2_tag;
	data_t     s2_value;
	data_t     alu_out;
	logic      take, s1_adv;

	assign issue.ready = !(s1_valid && s2_valid);
	assign take        = issue.valid && issue.ready;
	assign s1_adv      = s1_valid && (!s2_valid || result.ready);

	always_comb begin
		case (s1_func)
			ALU_ADD:   alu_out = s1_a + s1_b;
			ALU_SUB:   alu_out = s1_a - s1_b;
			ALU_AND:   alu_out = s1_a & s1_b;
			ALU_OR:    alu_out = s1_a | s1_b;
			ALU_XOR:   alu_out = s1_a ^ s1_b;
			ALU_SLL:   alu_out = s1_a << s1_b[5:0];
			ALU_SRL:   alu_out = s1_a >> s1_b[5:0];
			default:   alu_out = {{(DATA_W-1){1'b0}}, s1_a == s1_b};  // CMPEQ
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= take || (s1_valid && !s1_adv);
			s2_valid <= s1_adv || (s2_valid && !result.ready);
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			s1_func <= issue.func;
			s1_a    <= issue.opa;
			s1_b    <= issue.opb;
			s1_dest <= issue.dest;
		end
		if (s1_adv) begin
			s2_tag   <= s1_dest;
			s2_value <= alu_out;
		end
	end

	assign result.valid = s2_valid;
	assign result.tag   = s2_tag;
	assign result.value = s2_value;

endmodule

// File: rtl/cdb_arbiter.sv
/*
 * CDB arbiter
 * Picks one lane result per cycle for the single-wide CDB.
 * Round-robin, search starts after the lane granted last
 */
module cdb_arbiter import core_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	result_if.arb_side results [NUM_LANES],
	output logic      cdb_valid,
	output ptag_t     cdb_tag,
	output data_t     cdb_value
);

	lane_mask_t rr_last;  // One-hot, lane granted last
	lane_mask_t lane_valid, lane_ready, grant;
	ptag_t      lane_tag [NUM_LANES];
	data_t      lane_value [NUM_LANES];

	// A lane is ready when no lane ahead of it in the rotation is valid
	always_comb begin
		int unsigned last_idx;
		int unsigned idx;
		logic        blocked;
		last_idx   = 0;
		blocked    = 1'b0;
		lane_ready = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (rr_last[l])
				last_idx = l;
		end
		for (int off = 1; off <= NUM_LANES; off++) begin
			idx             = (last_idx + off) % NUM_LANES;
			lane_ready[idx] = !blocked;
			blocked         = blocked || lane_valid[idx];
		end
	end

	assign grant = lane_valid & lane_ready;

	always_comb begin
		cdb_valid = 1'b0;
		cdb_tag   = '0;
		cdb_value = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (grant[l]) begin
				cdb_valid = 1'b1;
				cdb_tag   = lane_tag[l];
				cdb_value = lane_value[l];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			rr_last <= lane_mask_t'(1) << (NUM_LANES - 1);  // Lane 0 first
		else if (|grant)
			rr_last <= grant;
	end

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		assign lane_valid[l]    = results[l].valid;
		assign lane_tag[l]      = results[l].tag;
		assign lane_value[l]    = results[l].value;
		assign results[l].ready = lane_ready[l];
	end

endmodule

// File: rtl/ooo_issue_core.sv
/*
 * Out-of-order issue core
 * Dispatch into the reservation station, operand lookup in the
 * physical register file, three ALU lanes and one shared CDB
 */
module ooo_issue_core import core_pkg::*, isa_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       dispatch_valid,
	input  alu_func_t  dispatch_func,
	input  ptag_t      dispatch_dest,
	input  ptag_t      dispatch_src_a,
	input  logic       dispatch_opb_is_imm,
	input  opb_field_t dispatch_opb,
	output logic       dispatch_ready,
	output logic       cdb_valid,
	output ptag_t      cdb_tag,
	output data_t      cdb_value
);

	dispatch_t dispatch_instr;
	ptag_t     rd_tag_a, rd_tag_b, alloc_tag;
	data_t     rd_value_a, rd_value_b;
	logic      rd_ready_a, rd_ready_b, alloc_valid;

	issue_if  issue_bus [NUM_LANES] ();
	result_if result_bus [NUM_LANES] ();

	assign dispatch_instr = '{
		func:       dispatch_func,
		dest:       dispatch_dest,
		src_a:      dispatch_src_a,
		opb_is_imm: dispatch_opb_is_imm,
		opb:        dispatch_opb
	};

	res_station rs0 (
		.clock          (clock),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_instr (dispatch_instr),
		.dispatch_ready (dispatch_ready),
		.rd_tag_a       (rd_tag_a),
		.rd_tag_b       (rd_tag_b),
		.rd_value_a     (rd_value_a),
		.rd_ready_a     (rd_ready_a),
		.rd_value_b     (rd_value_b),
		.rd_ready_b     (rd_ready_b),
		.alloc_valid    (alloc_valid),
		.alloc_tag      (alloc_tag),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_value      (cdb_value),
		.issue          (issue_bus)
	);

	phys_reg_file prf0 (
		.clock       (clock),
		.rst_n       (rst_n),
		.rd_tag_a    (rd_tag_a),
		.rd_tag_b    (rd_tag_b),
		.alloc_valid (alloc_valid),
		.alloc_tag   (alloc_tag),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_value   (cdb_value),
		.rd_value_a  (rd_value_a),
		.rd_ready_a  (rd_ready_a),
		.rd_value_b  (rd_value_b),
		.rd_ready_b  (rd_ready_b)
	);

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_alu
		alu_lane alu0 (
			.clock  (clock),
			.rst_n  (rst_n),
			.issue  (issue_bus[l]),
			.result (result_bus[l])
		);
	end

	cdb_arbiter arb0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.results   (result_bus),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.cdb_value (cdb_value)
	);

endmodule

// File: sim/issue_core_sva.sv
/*
 * Issue core assertions
 * Payload stability on every result handshake, distinct entries
 * across lanes issued together, plus sanity of the CDB broadcast
 * around reset
 */
module issue_core_sva import core_pkg::*; (
	input logic                                       clock,
	input logic                                       rst_n,
	input logic                                       cdb_valid,
	input ptag_t                                      cdb_tag,
	input lane_mask_t                                 iss_valid,
	input logic [NUM_LANES-1:0][3+TAG_W+2*DATA_W-1:0] iss_pay,
	input lane_mask_t                                 res_valid,
	input lane_mask_t                                 res_ready,
	input logic [NUM_LANES-1:0][TAG_W+DATA_W-1:0]     res_pay
);

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		// Destination tag sits just above both operands
		a_issue_distinct: assert property (@(posedge clock) disable iff (!rst_n)
			iss_valid[l] && iss_valid[(l+1)%NUM_LANES] |->
			iss_pay[l][2*DATA_W +: TAG_W] != iss_pay[(l+1)%NUM_LANES][2*DATA_W +: TAG_W])
			else $error("Lanes %0d and %0d were issued the same destination tag", l,
				(l+1)%NUM_LANES);

		a_result_hold: assert property (@(posedge clock) disable iff (!rst_n)
			res_valid[l] && !res_ready[l] |=> res_valid[l] && $stable(res_pay[l]))
			else $error("Result payload dropped or changed before transfer on lane %0d", l);
	end

	a_cdb_tag: assert property (@(posedge clock) disable iff (!rst_n)
		cdb_valid |-> cdb_tag != '0)
		else $error("CDB broadcast carries tag 0");

	// Lanes are empty right after reset
	a_cdb_quiet: assert property (@(posedge clock) $rose(rst_n) |-> !cdb_valid)
		else $error("CDB valid in the first cycle after reset");

endmodule

bind ooo_issue_core issue_core_sva sva_i (
	.clock     (clock),
	.rst_n     (rst_n),
	.cdb_valid (cdb_valid),
	.cdb_tag   (cdb_tag),
	.iss_valid ({issue_bus[2].valid, issue_bus[1].valid, issue_bus[0].valid}),
	.iss_pay   ({issue_bus[2].func, issue_bus[2].dest, issue_bus[2].opa, issue_bus[2].opb,
		issue_bus[1].func, issue_bus[1].dest, issue_bus[1].opa, issue_bus[1].opb,
		issue_bus[0].func, issue_bus[0].dest, issue_bus[0].opa, issue_bus[0].opb}),
	.res_valid ({result_bus[2].valid, result_bus[1].valid, result_bus[0].valid}),
	.res_ready ({result_bus[2].ready, result_bus[1].ready, result_bus[0].ready}),
	.res_pay   ({result_bus[2].tag, result_bus[2].value, result_bus[1].tag,
		result_bus[1].value, result_bus[0].tag, result_bus[0].value})
);

// File: sim/tb_issue_core.sv
/*
 * Testbench for the out-of-order issue core
 * Reads dispatches from the stimulus file, drives them on falling
 * edges, models the value of every destination tag and checks each
 * CDB broadcast against the model by tag
 */
module tb_issue_core import core_pkg::*, isa_pkg::*; ();

	logic       clock;
	logic       rst_n;
	logic       dispatch_valid;
	alu_func_t  dispatch_func;
	ptag_t      dispatch_dest;
	ptag_t      dispatch_src_a;
	logic       dispatch_opb_is_imm;
	opb_field_t dispatch_opb;
	logic       dispatch_ready;
	logic       cdb_valid;
	ptag_t      cdb_tag;
	data_t      cdb_value;

	dispatch_t           stim_q [$];
	logic                idle_q [$];
	data_t               file_exp_q [$];
	ptag_t               bcast_q [$];
	data_t               model_val [NUM_TAGS];
	logic [31:0]         lfsr;
	int                  n_lines;
	int                  bcast_count;
	int                  cycle_count;
	int                  cycle_limit;

	ooo_issue_core dut_i (
		.clock               (clock),
		.rst_n               (rst_n),
		.dispatch_valid      (dispatch_valid),
		.dispatch_func       (dispatch_func),
		.dispatch_dest       (dispatch_dest),
		.dispatch_src_a      (dispatch_src_a),
		.dispatch_opb_is_imm (dispatch_opb_is_imm),
		.dispatch_opb        (dispatch_opb),
		.dispatch_ready      (dispatch_ready),
		.cdb_valid           (cdb_valid),
		.cdb_tag             (cdb_tag),
		.cdb_value           (cdb_value)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic fail_with(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_with($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_tag(input string name, input ptag_t got, input ptag_t exp);
		if (got !== exp)
			fail_with($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_value(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			fail_with($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
	endtask

	// Galois form with taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr  = lfsr_next(lfsr);
		end
	endtask

	function automatic data_t model_alu(input alu_func_t f, input data_t a, input data_t b);
		data_t r;
		case (f)
			ALU_ADD: r = a + b;
			ALU_SUB: r = a - b;
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_XOR: r = a ^ b;
			ALU_SLL: r = a << b[5:0];  // Shift amount from the low 6 bits
			ALU_SRL: r = a >> b[5:0];
			default: r = (a == b) ? data_t'(1) : data_t'(0);
		endcase
		return r;
	endfunction

	task automatic load_stimulus();
		int                  fd;
		int                  n_fields;
		string               line;
		logic [63:0]         f_func, f_dest, f_src, f_imm, f_opb, f_idle, f_exp;
		dispatch_t           d;
		logic [NUM_TAGS-1:0] defined;
		defined    = '0;
		defined[0] = 1'b1;
		fd = $fopen("sim/issue_stimulus.hex", "r");
		if (fd == 0)
			fail_with("Could not open the stimulus file sim/issue_stimulus.hex");
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 2 || line.substr(0, 1) == "//")
				continue;
			n_fields = $sscanf(line, "%h %h %h %h %h %h %h",
				f_func, f_dest, f_src, f_imm, f_opb, f_idle, f_exp);
			if (n_fields != 7)
				fail_with($sformatf("Stimulus line has %0d fields instead of 7", n_fields));
			d.func       = alu_func_t'(f_func[2:0]);
			d.dest       = f_dest[TAG_W-1:0];
			d.src_a      = f_src[TAG_W-1:0];
			d.opb_is_imm = f_imm[0];
			d.opb.imm    = f_opb[IMM_W-1:0];
			if (d.dest == '0 || defined[d.dest])
				fail_with($sformatf("Stimulus reuses destination tag %0h", d.dest));
			if (!defined[d.src_a] || (!d.opb_is_imm && !defined[d.opb.src.tag]))
				fail_with($sformatf("Stimulus for tag %0h reads an unproduced tag", d.dest));
			defined[d.dest] = 1'b1;
			stim_q.push_back(d);
			idle_q.push_back(f_idle[0]);
			file_exp_q.push_back(f_exp);
		end
		$fclose(fd);
	endtask

	// Values follow file order since every source was produced earlier
	task automatic build_model();
		dispatch_t d;
		data_t     b;
		for (int t = 0; t < NUM_TAGS; t++)
			model_val[t] = '0;
		for (int i = 0; i < stim_q.size(); i++) begin
			d = stim_q[i];
			b = d.opb_is_imm ? data_t'(d.opb.imm) : model_val[d.opb.src.tag];
			model_val[d.dest] = model_alu(d.func, model_val[d.src_a], b);
			if (model_val[d.dest] !== file_exp_q[i])
				fail_with($sformatf("Stimulus line %0d lists %h but the model gives %h",
					i, file_exp_q[i], model_val[d.dest]));
		end
	endtask

	task automatic drive_dispatch(input dispatch_t d);
		dispatch_valid      = 1'b1;
		dispatch_func       = d.func;
		dispatch_dest       = d.dest;
		dispatch_src_a      = d.src_a;
		dispatch_opb_is_imm = d.opb_is_imm;
		dispatch_opb        = d.opb;
	endtask

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
			fail_with($sformatf("Timeout, the run did not finish in %0d cycles", cycle_limit));
	end

	// CDB outputs are stable by the falling edge
	always @(negedge clock) begin
		if (rst_n && cdb_valid) begin
			check_value("cdb_value", cdb_value, model_val[cdb_tag]);
			bcast_q.push_back(cdb_tag);
			bcast_count++;
		end
	end

	initial begin
		int      gap;
		logic    accepted;
		ptag_t   want_q [$];
		rst_n               = 1'b0;
		dispatch_valid      = 1'b0;
		dispatch_func       = ALU_ADD;
		dispatch_dest       = '0;
		dispatch_src_a      = '0;
		dispatch_opb_is_imm = 1'b0;
		dispatch_opb        = '0;
		lfsr                = 32'h2642_86e0;
		bcast_count         = 0;
		cycle_count         = 0;
		load_stimulus();
		build_model();
		n_lines     = stim_q.size();
		cycle_limit = 16 * n_lines + 200;

		repeat (16) begin
			@(negedge clock);
			check_bit("cdb_valid", cdb_valid, 1'b0);
			check_bit("dispatch_ready", dispatch_ready, 1'b1);
		end
		rst_n = 1'b1;
		@(negedge clock);
		check_bit("cdb_valid", cdb_valid, 1'b0);  // First cycle out of reset
		check_bit("dispatch_ready", dispatch_ready, 1'b1);

		for (int i = 0; i < n_lines; i++) begin
			if (idle_q[i]) begin
				dispatch_valid = 1'b0;
				draw_bits(2, gap);
				repeat (gap) @(negedge clock);
			end
			drive_dispatch(stim_q[i]);
			do begin
				accepted = dispatch_ready;  // Registered and holds until the next edge
				@(negedge clock);
			end while (!accepted);
		end
		dispatch_valid = 1'b0;

		wait (bcast_count >= n_lines);
		repeat (20) @(negedge clock);  // Room for any stray broadcast

		for (int i = 0; i < n_lines; i++)
			want_q.push_back(stim_q[i].dest);
		want_q.sort();
		bcast_q.sort();
		for (int i = 0; i < want_q.size() && i < bcast_q.size(); i++)
			check_tag("cdb_tag", bcast_q[i], want_q[i]);

		if (bcast_count != n_lines) begin
			fail_with($sformatf("Saw %0d broadcasts for %0d dispatched lines",
				bcast_count, n_lines));
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// File: sim/issue_stimulus.hex
// func dest src_a opb_is_imm opb idle expected, all hex
// idle 1 allows 0 to 3 random idle cycles before the line, idle 0 dispatches back to back
0 01 00 1 1234 1 0000000000001234
0 02 00 1 00f0 1 00000000000000f0
0 03 00 1 ffff 1 000000000000ffff
0 04 00 1 0004 1 0000000000000004
5 05 03 1 0030 1 ffff000000000000
6 06 05 0 0004 1 0ffff00000000000
3 07 06 0 0001 1 0ffff00000001234
1 08 07 1 0234 1 0ffff00000001000
4 09 08 0 0002 1 0ffff000000010f0
2 0a 09 1 ff0f 1 0000000000001000
7 0b 0a 0 0008 1 0000000000000000
7 0c 0a 1 1000 1 0000000000000001
1 0d 0b 0 000c 1 ffffffffffffffff
0 0e 0d 0 000d 1 fffffffffffffffe
0 0f 0e 1 0003 1 0000000000000001
5 10 0f 1 003f 0 8000000000000000
6 11 10 0 0004 0 0800000000000000
0 12 00 1 0aaa 0 0000000000000aaa
0 13 00 1 0bbb 0 0000000000000bbb
3 14 11 0 000f 0 0800000000000001
0 15 00 1 0ccc 0 0000000000000ccc
4 16 12 0 0013 0 0000000000000111

// File: sources.f
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/lane_ifs.sv
rtl/phys_reg_file.sv
rtl/res_station.sv
rtl/alu_lane.sv
rtl/cdb_arbiter.sv
rtl/ooo_issue_core.sv
sim/issue_core_sva.sv
sim/tb_issue_core.sv

// File: Makefile
TOP := tb_issue_core

.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "CHECKS FAILED" sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
